//--- logic/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Bus widths
`define ADDR_N 16
`define DATA_N 8

// First opcode fetch after reset
`define RESET_PC 16'h0200

// Flag positions in P, as on the 6502
`define STATUS_C 0
`define STATUS_Z 1
`define STATUS_V 6
`define STATUS_N 7

`endif

//--- logic/cpu_pkg.sv
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

	typedef logic [`ADDR_N - 1:0] addr_t;
	typedef logic [`DATA_N - 1:0] data_t;

	typedef enum logic [2:0] {
		ALU_PASS_B,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_INC,
		ALU_DEC
	} alu_func_e;

	typedef enum logic [1:0] {SRC_A_A, SRC_A_X, SRC_A_Y, SRC_A_ZERO} src_a_e;
	typedef enum logic {SRC_B_IMM, SRC_B_A} src_b_e;
	typedef enum logic [1:0] {DST_NONE, DST_A, DST_X, DST_Y} dst_e;
	typedef enum logic [1:0] {MODE_IMPLIED, MODE_IMMEDIATE, MODE_ABSOLUTE, MODE_RELATIVE} mode_e;
	typedef enum logic [1:0] {KIND_ALU, KIND_STORE, KIND_JUMP, KIND_BRANCH} kind_e;

	typedef struct packed {
		logic n;
		logic v;
		logic z;
		logic c;
	} status_t;

	// Decoded instruction
	typedef struct packed {
		kind_e kind;
		mode_e mode;
		alu_func_e alu_func;
		src_a_e src_a;
		src_b_e src_b;
		dst_e dst;
		status_t upd;
		logic carry_set;
		logic carry_clr;
		src_a_e store_src;
		// Branch tests the flags in br_sel against br_val
		status_t br_sel;
		logic br_val;
	} ctrl_t;

	typedef struct packed {
		data_t res;
		status_t flags;
	} alu_res_t;

	// Memory request
	typedef struct packed {
		addr_t addr;
		data_t data;
		logic we;
	} bus_t;

endpackage

`default_nettype wire

//--- logic/idec.sv
`default_nettype none

module idec import cpu_pkg::*; (
	input wire data_t opcode_i,
	output ctrl_t ctrl_o
);

localparam status_t UPD_NONE = '{n: 1'b0, v: 1'b0, z: 1'b0, c: 1'b0};
localparam status_t UPD_NZ = '{n: 1'b1, v: 1'b0, z: 1'b1, c: 1'b0};
localparam status_t UPD_NZC = '{n: 1'b1, v: 1'b0, z: 1'b1, c: 1'b1};
localparam status_t UPD_NVZC = '{n: 1'b1, v: 1'b1, z: 1'b1, c: 1'b1};
localparam status_t SEL_Z = '{n: 1'b0, v: 1'b0, z: 1'b1, c: 1'b0};
localparam status_t SEL_C = '{n: 1'b0, v: 1'b0, z: 1'b0, c: 1'b1};

always_comb begin
	// Anything unknown runs as an implied NOP
	ctrl_o.kind = KIND_ALU;
	ctrl_o.mode = MODE_IMPLIED;
	ctrl_o.alu_func = ALU_PASS_B;
	ctrl_o.src_a = SRC_A_ZERO;
	ctrl_o.src_b = SRC_B_IMM;
	ctrl_o.dst = DST_NONE;
	ctrl_o.upd = UPD_NONE;
	ctrl_o.carry_set = 1'b0;
	ctrl_o.carry_clr = 1'b0;
	ctrl_o.store_src = SRC_A_A;
	ctrl_o.br_sel = SEL_Z;
	ctrl_o.br_val = 1'b0;

	case (opcode_i)
		// Immediate loads
		8'hA9, 8'hA2, 8'hA0: begin
			ctrl_o.mode = MODE_IMMEDIATE;
			ctrl_o.upd = UPD_NZ;
			ctrl_o.dst = (opcode_i == 8'hA9) ? DST_A : (opcode_i == 8'hA2) ? DST_X : DST_Y;
		end
		// ADC, SBC, AND, ORA, EOR, CMP
		8'h69, 8'hE9, 8'h29, 8'h09, 8'h49, 8'hC9: begin
			ctrl_o.mode = MODE_IMMEDIATE;
			ctrl_o.src_a = SRC_A_A;
			ctrl_o.dst = DST_A;
			ctrl_o.upd = UPD_NZ;
			case (opcode_i)
				8'h69: begin
					ctrl_o.alu_func = ALU_ADD;
					ctrl_o.upd = UPD_NVZC;
				end
				8'hE9: begin
					ctrl_o.alu_func = ALU_SUB;
					ctrl_o.upd = UPD_NVZC;
				end
				8'h29: ctrl_o.alu_func = ALU_AND;
				8'h09: ctrl_o.alu_func = ALU_OR;
				8'h49: ctrl_o.alu_func = ALU_XOR;
				default: begin
					// CMP subtracts with borrow cleared and keeps A
					ctrl_o.alu_func = ALU_SUB;
					ctrl_o.dst = DST_NONE;
					ctrl_o.upd = UPD_NZC;
					ctrl_o.carry_set = 1'b1;
				end
			endcase
		end
		// INX, INY, DEX, DEY
		8'hE8, 8'hC8, 8'hCA, 8'h88: begin
			ctrl_o.alu_func = (opcode_i == 8'hE8 || opcode_i == 8'hC8) ? ALU_INC : ALU_DEC;
			ctrl_o.src_a = (opcode_i == 8'hE8 || opcode_i == 8'hCA) ? SRC_A_X : SRC_A_Y;
			ctrl_o.dst = (opcode_i == 8'hE8 || opcode_i == 8'hCA) ? DST_X : DST_Y;
			ctrl_o.upd = UPD_NZ;
		end
		// TAX, TAY
		8'hAA, 8'hA8: begin
			ctrl_o.src_b = SRC_B_A;
			ctrl_o.dst = (opcode_i == 8'hAA) ? DST_X : DST_Y;
			ctrl_o.upd = UPD_NZ;
		end
		// TXA, TYA: OR with the zero operand of implied forms
		8'h8A, 8'h98: begin
			ctrl_o.alu_func = ALU_OR;
			ctrl_o.src_a = (opcode_i == 8'h8A) ? SRC_A_X : SRC_A_Y;
			ctrl_o.dst = DST_A;
			ctrl_o.upd = UPD_NZ;
		end
		8'h18: ctrl_o.carry_clr = 1'b1;
		8'h38: ctrl_o.carry_set = 1'b1;
		// Absolute stores
		8'h8D, 8'h8E, 8'h8C: begin
			ctrl_o.kind = KIND_STORE;
			ctrl_o.mode = MODE_ABSOLUTE;
			ctrl_o.store_src = (opcode_i == 8'h8D) ? SRC_A_A :
				(opcode_i == 8'h8E) ? SRC_A_X : SRC_A_Y;
		end
		8'h4C: begin
			ctrl_o.kind = KIND_JUMP;
			ctrl_o.mode = MODE_ABSOLUTE;
		end
		// BEQ, BNE, BCS, BCC
		8'hF0, 8'hD0, 8'hB0, 8'h90: begin
			ctrl_o.kind = KIND_BRANCH;
			ctrl_o.mode = MODE_RELATIVE;
			ctrl_o.br_sel = (opcode_i == 8'hF0 || opcode_i == 8'hD0) ? SEL_Z : SEL_C;
			ctrl_o.br_val = (opcode_i == 8'hF0 || opcode_i == 8'hB0);
		end
		default: ;
	endcase
end

endmodule

`default_nettype wire

//--- logic/alu.sv
`default_nettype none

`include "cpu_cfg.svh"

module alu import cpu_pkg::*; (
	input wire alu_func_e func_i,
	input wire data_t a_i,
	input wire data_t b_i,
	input wire carry_i,
	output alu_res_t res_o
);

data_t b_add;
data_t res;
logic [`DATA_N:0] sum;

// Shared adder, subtract is a plus inverted b plus carry
assign b_add = (func_i == ALU_SUB) ? ~b_i : b_i;
assign sum = {1'b0, a_i} + {1'b0, b_add} + {{`DATA_N{1'b0}}, carry_i};

always_comb begin
	case (func_i)
		ALU_PASS_B: res = b_i;
		ALU_ADD,
		ALU_SUB: res = sum[`DATA_N - 1:0];
		ALU_AND: res = a_i & b_i;
		ALU_OR: res = a_i | b_i;
		ALU_XOR: res = a_i ^ b_i;
		ALU_INC: res = a_i + 1'b1;
		ALU_DEC: res = a_i - 1'b1;
		default: res = b_i;
	endcase
end

always_comb begin
	res_o.res = res;
	res_o.flags.n = res[`DATA_N - 1];
	res_o.flags.z = (res == '0);
	// Signed overflow: like signs in, other sign out
	res_o.flags.v = (a_i[`DATA_N - 1] == b_add[`DATA_N - 1]) &&
		(sum[`DATA_N - 1] != a_i[`DATA_N - 1]);
	res_o.flags.c = sum[`DATA_N];
end

endmodule

`default_nettype wire

//--- logic/arch_regs.sv
`default_nettype none

`include "cpu_cfg.svh"

module arch_regs import cpu_pkg::*; (
	input wire clk_i,
	input wire rst_n_i,
	input wire ctrl_t ctrl_i,
	input wire exec_i,
	input wire data_t imm_i,
	input wire alu_res_t res_i,
	output data_t a_o,
	output data_t b_o,
	output status_t status_o,
	output data_t store_o
);

data_t acc_q, x_q, y_q, p_q;
status_t flags;

function automatic data_t pick(input src_a_e sel, input data_t acc, input data_t x,
		input data_t y);
	case (sel)
		SRC_A_A: pick = acc;
		SRC_A_X: pick = x;
		SRC_A_Y: pick = y;
		default: pick = '0;
	endcase
endfunction

assign a_o = pick(ctrl_i.src_a, acc_q, x_q, y_q);
assign b_o = (ctrl_i.src_b == SRC_B_A) ? acc_q : imm_i;
assign store_o = pick(ctrl_i.store_src, acc_q, x_q, y_q);

// Carry seen by the ALU and the merge, with SEC/CLC/CMP override
always_comb begin
	flags.n = p_q[`STATUS_N];
	flags.v = p_q[`STATUS_V];
	flags.z = p_q[`STATUS_Z];
	flags.c = (p_q[`STATUS_C] | ctrl_i.carry_set) & ~ctrl_i.carry_clr;
end

assign status_o = flags;

always_ff @(posedge clk_i) begin
	if (!rst_n_i) begin
		acc_q <= '0;
		x_q <= '0;
		y_q <= '0;
		p_q <= '0;
	end else if (exec_i) begin
		case (ctrl_i.dst)
			DST_A: acc_q <= res_i.res;
			DST_X: x_q <= res_i.res;
			DST_Y: y_q <= res_i.res;
			default: ;
		endcase
		p_q[`STATUS_N] <= ctrl_i.upd.n ? res_i.flags.n : flags.n;
		p_q[`STATUS_V] <= ctrl_i.upd.v ? res_i.flags.v : flags.v;
		p_q[`STATUS_Z] <= ctrl_i.upd.z ? res_i.flags.z : flags.z;
		p_q[`STATUS_C] <= ctrl_i.upd.c ? res_i.flags.c : flags.c;
	end
end

endmodule

`default_nettype wire

//--- logic/sequencer.sv
`default_nettype none

`include "cpu_cfg.svh"

module sequencer import cpu_pkg::*; (
	input wire clk_i,
	input wire rst_n_i,
	input wire ctrl_t ctrl_i,
	input wire status_t status_i,
	input wire data_t store_i,
	input wire data_t data_i,
	output data_t opcode_o,
	output data_t imm_o,
	output logic exec_o,
	output bus_t bus_o,
	output logic dbg_o
);

typedef enum logic [1:0] {FETCH, OPER_LO, OPER_HI, WRITE} state_e;

state_e state_q;
addr_t pc_q;
addr_t pc_inc;
addr_t br_target;
data_t opcode_q, lo_q, hi_q;
logic taken;

assign pc_inc = pc_q + 1'b1;
// Offset is relative to the byte after the branch
assign br_target = pc_inc + {{(`ADDR_N - `DATA_N){data_i[`DATA_N - 1]}}, data_i};
assign taken = ((|(status_i & ctrl_i.br_sel)) == ctrl_i.br_val);

always_ff @(posedge clk_i) begin
	if (!rst_n_i) begin
		state_q <= FETCH;
		pc_q <= `RESET_PC;
	end else begin
		case (state_q)
			FETCH: begin
				pc_q <= pc_inc;
				state_q <= OPER_LO;
			end
			OPER_LO: begin
				case (ctrl_i.kind)
					KIND_ALU: begin
						if (ctrl_i.mode == MODE_IMMEDIATE) begin
							pc_q <= pc_inc;
						end
						state_q <= FETCH;
					end
					KIND_BRANCH: begin
						pc_q <= taken ? br_target : pc_inc;
						state_q <= FETCH;
					end
					default: begin
						pc_q <= pc_inc;
						state_q <= OPER_HI;
					end
				endcase
			end
			OPER_HI: begin
				if (ctrl_i.kind == KIND_JUMP) begin
					pc_q <= {data_i, lo_q};
					state_q <= FETCH;
				end else begin
					pc_q <= pc_inc;
					state_q <= WRITE;
				end
			end
			default: state_q <= FETCH;
		endcase
	end
end

// Opcode and address byte latches
always_ff @(posedge clk_i) begin
	if (state_q == FETCH) begin
		opcode_q <= data_i;
	end
	if (state_q == OPER_LO) begin
		lo_q <= data_i;
	end
	if (state_q == OPER_HI) begin
		hi_q <= data_i;
	end
end

assign opcode_o = opcode_q;
// Implied forms see a zero operand
assign imm_o = (ctrl_i.mode == MODE_IMMEDIATE) ? data_i : '0;
assign exec_o = (state_q == OPER_LO) && (ctrl_i.kind == KIND_ALU);
// Strobe held low through reset
assign dbg_o = rst_n_i && (state_q == FETCH);

always_comb begin
	bus_o.addr = (state_q == WRITE) ? {hi_q, lo_q} : pc_q;
	bus_o.data = store_i;
	bus_o.we = (state_q == WRITE);
end

endmodule

`default_nettype wire

//--- logic/cpu.sv
`default_nettype none

module cpu import cpu_pkg::*; (
	input wire clk_i,
	input wire rst_n_i,
	input wire data_t data_i,
	output addr_t addr_o,
	output data_t data_o,
	output logic we_o,
	output logic dbg_o
);

ctrl_t ctrl;
data_t opcode;
data_t imm;
data_t opnd_a, opnd_b;
data_t store_val;
status_t status;
alu_res_t alu_res;
logic exec;
bus_t bus;

idec idec0 (
	.opcode_i(opcode),
	.ctrl_o(ctrl)
);

alu alu0 (
	.func_i(ctrl.alu_func),
	.a_i(opnd_a),
	.b_i(opnd_b),
	.carry_i(status.c),
	.res_o(alu_res)
);

arch_regs regs0 (
	.clk_i(clk_i),
	.rst_n_i(rst_n_i),
	.ctrl_i(ctrl),
	.exec_i(exec),
	.imm_i(imm),
	.res_i(alu_res),
	.a_o(opnd_a),
	.b_o(opnd_b),
	.status_o(status),
	.store_o(store_val)
);

sequencer seq0 (
	.clk_i(clk_i),
	.rst_n_i(rst_n_i),
	.ctrl_i(ctrl),
	.status_i(status),
	.store_i(store_val),
	.data_i(data_i),
	.opcode_o(opcode),
	.imm_o(imm),
	.exec_o(exec),
	.bus_o(bus),
	.dbg_o(dbg_o)
);

// Memory pins
assign addr_o = bus.addr;
assign data_o = bus.data;
assign we_o = bus.we;

endmodule

`default_nettype wire

//--- tb/cpu_ref.svh
`ifndef CPU_REF_SVH
`define CPU_REF_SVH

// Architectural state of the model
data_t ref_mem [0:65535];
data_t ref_a;
data_t ref_x;
data_t ref_y;
logic ref_n;
logic ref_v;
logic ref_z;
logic ref_c;
addr_t ref_pc;

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

function automatic void ref_reset();
	ref_a = 8'h00;
	ref_x = 8'h00;
	ref_y = 8'h00;
	ref_n = 1'b0;
	ref_v = 1'b0;
	ref_z = 1'b0;
	ref_c = 1'b0;
	ref_pc = `RESET_PC;
endfunction

function automatic data_t set_nz(input data_t r);
	ref_n = r[7];
	ref_z = (r == 8'h00);
	return r;
endfunction

// ADC on the 6502, SBC passes the inverted operand
function automatic void add_carry(input data_t b);
	logic [8:0] s;
	s = {1'b0, ref_a} + {1'b0, b} + {8'h00, ref_c};
	ref_v = (ref_a[7] == b[7]) && (s[7] != ref_a[7]);
	ref_c = s[8];
	ref_a = set_nz(s[7:0]);
endfunction

function automatic addr_t ref_step(output bus_t st, output logic st_v);
	data_t op;
	data_t b;
	addr_t ea;
	addr_t next;
	logic [8:0] diff;
	op = ref_mem[ref_pc];
	b = ref_mem[ref_pc + 16'd1];
	ea = {ref_mem[ref_pc + 16'd2], b};
	next = ref_pc + 16'd1;
	st = '0;
	st_v = 1'b0;
	if (op inside {8'hA9, 8'hA2, 8'hA0, 8'h69, 8'hE9, 8'h29, 8'h09, 8'h49, 8'hC9}) begin
		next = ref_pc + 16'd2;
	end
	case (op)
		8'hA9: ref_a = set_nz(b);
		8'hA2: ref_x = set_nz(b);
		8'hA0: ref_y = set_nz(b);
		8'h69: add_carry(b);
		8'hE9: add_carry(~b);
		8'h29: ref_a = set_nz(ref_a & b);
		8'h09: ref_a = set_nz(ref_a | b);
		8'h49: ref_a = set_nz(ref_a ^ b);
		8'hC9: begin
			// Compare leaves A alone, carry means no borrow
			diff = {1'b0, ref_a} + {1'b0, ~b} + 9'd1;
			ref_c = diff[8];
			void'(set_nz(diff[7:0]));
		end
		8'hE8: ref_x = set_nz(ref_x + 8'd1);
		8'hC8: ref_y = set_nz(ref_y + 8'd1);
		8'hCA: ref_x = set_nz(ref_x - 8'd1);
		8'h88: ref_y = set_nz(ref_y - 8'd1);
		8'hAA: ref_x = set_nz(ref_a);
		8'hA8: ref_y = set_nz(ref_a);
		8'h8A: ref_a = set_nz(ref_x);
		8'h98: ref_a = set_nz(ref_y);
		8'h18: ref_c = 1'b0;
		8'h38: ref_c = 1'b1;
		8'h8D, 8'h8E, 8'h8C: begin
			st.addr = ea;
			st.data = (op == 8'h8D) ? ref_a : (op == 8'h8E) ? ref_x : ref_y;
			st.we = 1'b1;
			st_v = 1'b1;
			ref_mem[ea] = st.data;
			next = ref_pc + 16'd3;
		end
		8'h4C: next = ea;
		8'hF0, 8'hD0, 8'hB0, 8'h90: begin
			next = ref_pc + 16'd2;
			if ((op == 8'hF0 && ref_z) || (op == 8'hD0 && !ref_z) ||
					(op == 8'hB0 && ref_c) || (op == 8'h90 && !ref_c)) begin
				next = next + {{8{b[7]}}, b};
			end
		end
		default: ;
	endcase
	ref_pc = next;
	return next;
endfunction

`endif

//--- tb/cpu_tb.sv
`default_nettype none

`include "cpu_cfg.svh"

module cpu_tb import cpu_pkg::*; ();

`include "cpu_ref.svh"

logic clk;
logic rst_n;
data_t rd_data;
addr_t addr;
data_t wr_data;
logic we;
logic dbg;

data_t mem [0:65535];
data_t prog [$];
data_t op_table [0:31];
logic [15:0] lfsr_q;
addr_t exp_pc;
bus_t exp_st;
logic exp_st_v;
bus_t seen_st;
logic seen_st_v;

cpu dut_i (
	.clk_i(clk),
	.rst_n_i(rst_n),
	.data_i(rd_data),
	.addr_o(addr),
	.data_o(wr_data),
	.we_o(we),
	.dbg_o(dbg)
);

always #5 clk = ~clk;

// Combinational read, write on the edge
assign rd_data = mem[addr];

always @(posedge clk) begin
	if (we) begin
		mem[addr] <= wr_data;
	end
end

task automatic stop_run();
	$display("Testbench failed");
	$fatal(1);
endtask

task automatic check_fetch(input string name, input addr_t exp, input addr_t act);
	if (exp !== act) begin
		$display("CHECK FAILED %s fetch expected %h actual %h", name, exp, act);
		stop_run();
	end
endtask

task automatic check_store(input string name, input bus_t exp, input bus_t act);
	if (exp !== act) begin
		$display("CHECK FAILED %s store expected %h actual %h", name, exp, act);
		stop_run();
	end
endtask

function automatic data_t rand_bits(input int n);
	data_t r;
	r = 8'h00;
	for (int i = 0; i < n; i++) begin
		lfsr_q = lfsr_next(lfsr_q);
		r = {r[6:0], lfsr_q[0]};
	end
	return r;
endfunction

task automatic emit(input data_t b);
	prog.push_back(b);
endtask

function automatic addr_t here();
	return addr_t'(`RESET_PC) + addr_t'(prog.size());
endfunction

task automatic emit_jmp(input addr_t target);
	emit(8'h4C);
	emit(target[7:0]);
	emit(target[15:8]);
endtask

// Both memories get the same pattern and program
task automatic load_memories();
	addr_t a;
	for (int i = 0; i < 65536; i++) begin
		a = addr_t'(i);
		mem[a] = a[15:8] ^ a[7:0] ^ 8'h3C;
		ref_mem[a] = mem[a];
	end
	for (int k = 0; k < prog.size(); k++) begin
		a = addr_t'(`RESET_PC) + addr_t'(k);
		mem[a] = prog[k];
		ref_mem[a] = prog[k];
	end
endtask

// Stores seen between two fetches are collected on the way
task automatic wait_fetch(input string name);
	logic found;
	found = 1'b0;
	seen_st_v = 1'b0;
	for (int n = 0; n < 10 && !found; n++) begin
		@(negedge clk);
		if (we) begin
			seen_st = '{addr: addr, data: wr_data, we: we};
			seen_st_v = 1'b1;
		end
		found = dbg;
	end
	if (!found) begin
		$display("Timed out in %s waiting for an opcode fetch", name);
		stop_run();
	end
endtask

task automatic compare_store(input string name);
	if (exp_st_v && !seen_st_v) begin
		$display("In %s a store to %h was expected but no write happened", name, exp_st.addr);
		stop_run();
	end else if (!exp_st_v && seen_st_v) begin
		$display("In %s an unexpected write to %h happened", name, seen_st.addr);
		stop_run();
	end else if (exp_st_v) begin
		check_store(name, exp_st, seen_st);
	end
endtask

task automatic run_program(input string name, input int count);
	@(posedge clk);
	#1 rst_n = 1'b0;
	@(posedge clk);
	#1;
	load_memories();
	ref_reset();
	@(negedge clk);
	if (we !== 1'b0) begin
		$display("In %s write enable was high during reset", name);
		stop_run();
	end
	@(posedge clk);
	#1 rst_n = 1'b1;
	exp_pc = `RESET_PC;
	exp_st_v = 1'b0;
	for (int i = 0; i < count; i++) begin
		wait_fetch(name);
		if (i > 0) begin
			compare_store(name);
		end
		check_fetch(name, exp_pc, addr);
		exp_pc = ref_step(exp_st, exp_st_v);
	end
	prog.delete();
endtask

task automatic build_loads();
	addr_t self;
	emit(8'hA9); emit(8'h5A);
	emit(8'hA2); emit(8'h80);
	emit(8'hA0); emit(8'h00);
	emit(8'h8D); emit(8'h00); emit(8'h03);
	emit(8'h8E); emit(8'h01); emit(8'h03);
	emit(8'h8C); emit(8'h02); emit(8'h03);
	emit(8'hAA); emit(8'h98); emit(8'hA8); emit(8'h8A);
	emit(8'hE8); emit(8'hC8); emit(8'hCA); emit(8'h88); emit(8'h88);
	emit(8'h8D); emit(8'h03); emit(8'h03);
	emit(8'h8E); emit(8'h04); emit(8'h03);
	emit(8'h8C); emit(8'h05); emit(8'h03);
	self = here();
	emit_jmp(self);
endtask

// Carry and overflow edges, seen through branches and stores
task automatic build_arith();
	emit(8'h18); emit(8'hA9); emit(8'h7F); emit(8'h69); emit(8'h01);
	emit(8'h8D); emit(8'h10); emit(8'h03);
	emit(8'hB0); emit(8'h02);
	emit(8'h69); emit(8'h80);
	emit(8'h8D); emit(8'h11); emit(8'h03);
	emit(8'hB0); emit(8'h02); emit(8'hA9); emit(8'hFF);
	emit(8'hF0); emit(8'h02); emit(8'hA9); emit(8'hEE);
	emit(8'h38); emit(8'hA9); emit(8'h00); emit(8'hE9); emit(8'h01);
	emit(8'h8D); emit(8'h12); emit(8'h03);
	emit(8'h90); emit(8'h02); emit(8'hEA); emit(8'hEA);
	emit(8'hC9); emit(8'hFF); emit(8'hD0); emit(8'h02);
	emit(8'hC9); emit(8'h10); emit(8'hD0); emit(8'h02); emit(8'hEA); emit(8'hEA);
	emit(8'h38); emit(8'hA9); emit(8'h80); emit(8'hE9); emit(8'h01);
	emit(8'h8D); emit(8'h13); emit(8'h03);
	emit(8'h29); emit(8'h0F); emit(8'h09); emit(8'h30); emit(8'h49); emit(8'hFF);
	emit(8'h8D); emit(8'h14); emit(8'h03);
	emit_jmp(here());
endtask

task automatic build_flow();
	emit(8'hA2); emit(8'h03);
	// Backward loop on X
	emit(8'hCA); emit(8'hD0); emit(8'hFD);
	emit_jmp(here() + 16'd5);
	emit(8'hEA); emit(8'hEA);
	emit(8'hA0); emit(8'h00); emit(8'hF0); emit(8'h01); emit(8'hEA);
	emit(8'hD0); emit(8'h01);
	emit(8'hA0); emit(8'h02);
	emit(8'h88); emit(8'hD0); emit(8'hFD);
	emit(8'h38); emit(8'h90); emit(8'h05); emit(8'hB0); emit(8'h01); emit(8'hEA);
	emit_jmp(here());
endtask

task automatic build_random();
	data_t op;
	op_table = '{8'hA9, 8'hA2, 8'hA0, 8'h69, 8'hE9, 8'h29, 8'h09, 8'h49,
		8'hC9, 8'hE8, 8'hC8, 8'hCA, 8'h88, 8'hAA, 8'hA8, 8'h8A,
		8'h98, 8'h18, 8'h38, 8'hEA, 8'h8D, 8'h8E, 8'h8C, 8'h4C,
		8'hF0, 8'hD0, 8'hB0, 8'h90, 8'hFF, 8'h02, 8'h69, 8'hE9};
	while (prog.size() < 1024) begin
		op = op_table[rand_bits(5)];
		emit(op);
		if (op inside {8'hA9, 8'hA2, 8'hA0, 8'h69, 8'hE9, 8'h29, 8'h09, 8'h49, 8'hC9,
				8'hF0, 8'hD0, 8'hB0, 8'h90}) begin
			emit(rand_bits(8));
		end else if (op inside {8'h8D, 8'h8E, 8'h8C, 8'h4C}) begin
			// Targets stay inside the code area 0200 to 05FF
			emit(rand_bits(8));
			emit(8'h02 + rand_bits(2));
		end
	end
endtask

initial begin
	clk = 1'b0;
	rst_n = 1'b0;
	lfsr_q = 16'd4;
	build_loads();
	run_program("loads", 24);
	build_arith();
	run_program("arith", 40);
	build_flow();
	run_program("flow", 30);
	build_random();
	run_program("random", 400);
	$display("Testbench passed");
	$finish;
end

endmodule

`default_nettype wire

//--- build.f
+incdir+logic
+incdir+tb
logic/cpu_pkg.sv
logic/idec.sv
logic/alu.sv
logic/arch_regs.sv
logic/sequencer.sv
logic/cpu.sv
tb/cpu_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"

test:
	verilator --binary -Wno-fatal -f build.f --top-module cpu_tb --Mdir obj_dir -o Vcpu_tb
	./obj_dir/Vcpu_tb

clean:
	rm -rf obj_dir
